// ==== nocRouterPort.f ====
rtl/nocPkg.sv
rtl/grantIf.sv
rtl/switchArbiter.sv
rtl/packetTimer.sv
rtl/flitCrossbar.sv
rtl/outputPortAlloc.sv
verification/outputPortAllocTb.sv

// ==== Makefile ====
TOP := outputPortAllocTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f nocRouterPort.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

// ==== verification/outputPortAllocTb.sv ====
`timescale 1ns/1ps

module outputPortAllocTb;
  import nocPkg::*;

  localparam int ClkPeriod     = 4;
  localparam int NumPackets    = 8; // per source.
  localparam int MaxLength     = 6;
  localparam int NumTests      = 6;
  localparam int TimeoutCycles = NumPackets * NumPorts * (MaxLength + 1) * 20 + 200;

  typedef enum int {
    testReset,
    testIntegrity,
    testAtomicity,
    testRoundRobin,
    testProtocol,
    testBackPressure
  } testT;

  logic                clk;
  logic                rst;
  flitT [NumPorts-1:0] inFlit;
  logic [NumPorts-1:0] inReq;
  logic [NumPorts-1:0] inAck;
  flitT                outFlit;
  logic                outReq;
  logic                outAck;

  logic [31:0]         rngState = 32'hd90;
  flitT                expQ [NumPorts][$]; // flits sent, per source port.
  int                  checks [NumTests];
  int                  fails [NumTests];
  int                  sentCount;
  int                  reqRises;
  int                  delivered;
  int                  holder;             // port the model expects on the output.
  int                  modelLeft;
  flitT                lastFlit;
  int                  atomPort;
  int                  atomLeft;
  int                  headsSeen;
  logic [NumPorts-1:0] prevAck;
  logic [NumPorts-1:0] prevReq;
  logic                prevOutReq;
  logic                prevOutAck;
  flitT                prevOutFlit;

  outputPortAlloc dut0 (.*);

  initial
  begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  function automatic logic [31:0] nextRandom();
    logic [31:0] x;
    x = rngState;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rngState = x;
    return x;
  endfunction

  // first requesting port after last, wrapping around.
  function automatic int pickPort(input logic [NumPorts-1:0] cand, input int last);
    int idx;
    int pick;
    pick = -1;
    for (int off = 1; off <= NumPorts; off++)
    begin
      idx = (last + off) % NumPorts;
      if (pick < 0 && cand[idx])
        pick = idx;
    end
    return pick;
  endfunction

  task automatic checkValue(input testT t, input logic [31:0] expected,
                            input logic [31:0] actual);
    checks[t]++;
    assert (expected == actual)
    else
    begin
      fails[t]++;
      $display("error %s: expected %0h actual %0h", t.name(), expected, actual);
    end
  endtask

  task automatic checkTrue(input testT t, input logic cond, input string what);
    checks[t]++;
    assert (cond)
    else
    begin
      fails[t]++;
      $display("%s failed: %s", t.name(), what);
    end
  endtask

  task automatic reportTest(input testT t);
    $display("%s: %0d checks, %0d failures", t.name(), checks[t], fails[t]);
  endtask

  task automatic waitAckLevel(input int p, input logic level);
    @(posedge clk);
    while (inAck[p] != level)
      @(posedge clk);
  endtask

  // one full four-phase cycle on input p.
  task automatic sendFlit(input int p, input flitT f);
    inFlit[p] = f;
    expQ[p].push_back(f);
    sentCount++;
    inReq[p] = 1'b1;
    waitAckLevel(p, 1'b1);
    #1 inReq[p] = 1'b0;
    waitAckLevel(p, 1'b0);
    #1;
  endtask

  task automatic runSource(input int p);
    int   len;
    flitT f;
    for (int k = 0; k < NumPackets; k++)
    begin
      len = int'(nextRandom() % (MaxLength + 1));
      f.kind = kindHead;
      f.payload = {3'(p), 1'b0, LengthWidth'(len)};
      sendFlit(p, f);
      for (int b = 1; b <= len; b++)
      begin
        f.kind = (b == len) ? kindTail : kindBody;
        f.payload = {3'(p), 13'(k * 8 + b)}; // port and sequence number.
        sendFlit(p, f);
      end
    end
  endtask

  task automatic observeFlit();
    flitT expected;
    reqRises++;
    if (outFlit.kind == kindHead)
    begin
      checkValue(testAtomicity, 0, atomLeft);
      atomPort = int'(outFlit.payload[15:13]);
      atomLeft = int'(outFlit.payload[LengthWidth-1:0]);
      if (headsSeen < NumPorts)
        checkValue(testRoundRobin, headsSeen, atomPort); // first round in index order.
      headsSeen++;
      checkValue(testRoundRobin, holder, atomPort);
    end
    else
    begin
      checkValue(testAtomicity, atomPort, int'(outFlit.payload[15:13]));
      checkTrue(testAtomicity, atomLeft > 0, "flit arrived after its packet was complete");
      atomLeft--;
    end
    checkTrue(testIntegrity, holder >= 0 && expQ[holder].size() > 0,
              "output request while no flit was expected");
    if (holder >= 0 && expQ[holder].size() > 0)
    begin
      expected = expQ[holder].pop_front();
      checkValue(testIntegrity, 32'(expected), 32'(outFlit));
      lastFlit = expected;
    end
  endtask

  always @(posedge clk)
  begin
    logic [NumPorts-1:0] cand;
    logic                packetEnd;
    if (rst)
    begin
      holder = -1;
      modelLeft = 0;
    end
    else
    begin
      for (int i = 0; i < NumPorts; i++)
      begin
        if (inAck[i] && !prevAck[i])
          checkTrue(testProtocol, inReq[i],
                    $sformatf("inAck of port %0d rose while its inReq was low", i));
        if (!inAck[i] && prevAck[i])
          checkTrue(testProtocol, !prevReq[i],
                    $sformatf("inAck of port %0d fell before its inReq dropped", i));
      end
      if (outReq && !prevOutReq)
        observeFlit();
      if (prevOutReq && !prevOutAck)
        checkValue(testProtocol, 32'(prevOutFlit), 32'(outFlit)); // held until acked.
      packetEnd = 1'b0;
      if (holder >= 0 && prevAck[holder] && !inAck[holder])
      begin
        delivered++;
        if (lastFlit.kind == kindHead)
          modelLeft = int'(lastFlit.payload[LengthWidth-1:0]);
        else
          modelLeft--;
        packetEnd = modelLeft == 0;
      end
      for (int i = 0; i < NumPorts; i++)
        cand[i] = inReq[i] && inFlit[i].kind == kindHead;
      if (holder < 0)
        holder = pickPort(cand, NumPorts - 1); // idle search starts at local.
      else if (packetEnd)
        holder = pickPort(cand, holder);
    end
    prevAck = inAck;
    prevReq = inReq;
    prevOutReq = outReq;
    prevOutAck = outAck;
    prevOutFlit = outFlit;
  end

  // downstream router, slow on purpose.
  initial
  begin
    int delay;
    outAck = 1'b0;
    forever
    begin
      @(posedge clk);
      if (outReq)
      begin
        delay = int'(nextRandom() % 4);
        repeat (delay) @(posedge clk);
        #1 outAck = 1'b1;
        @(posedge clk);
        while (outReq)
          @(posedge clk);
        #1 outAck = 1'b0;
      end
    end
  end

  initial
  begin
    #(TimeoutCycles * ClkPeriod);
    $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display("Checks failed");
    $finish;
  end

  initial
  begin
    int totalChecks;
    int totalFails;
    rst = 1'b1;
    inReq = '0;
    inFlit = '0;
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
    @(posedge clk);
    checkValue(testReset, 0, 32'(outReq));
    checkValue(testReset, 0, 32'(inAck));
    reportTest(testReset);
    #1;
    fork
      runSource(0);
      runSource(1);
      runSource(2);
      runSource(3);
      runSource(4);
    join
    @(posedge clk);
    for (int p = 0; p < NumPorts; p++)
      checkValue(testBackPressure, 0, expQ[p].size());
    checkValue(testBackPressure, sentCount, reqRises);
    checkValue(testBackPressure, sentCount, delivered);
    checkValue(testAtomicity, 0, atomLeft);
    for (int t = 1; t < NumTests; t++)
      reportTest(testT'(t));
    totalChecks = 0;
    totalFails = 0;
    for (int t = 0; t < NumTests; t++)
    begin
      totalChecks += checks[t];
      totalFails += fails[t];
    end
    $display("summary: %0d checks, %0d failures, %0d flits", totalChecks, totalFails,
             sentCount);
    if (totalFails == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// ==== rtl/outputPortAlloc.sv ====
`timescale 1ns/1ps

module outputPortAlloc (
  input  logic                                 clk,
  input  logic                                 rst,
  input  nocPkg::flitT [nocPkg::NumPorts-1:0]  inFlit,
  input  logic [nocPkg::NumPorts-1:0]          inReq,
  output logic [nocPkg::NumPorts-1:0]          inAck,
  output nocPkg::flitT                         outFlit,
  output logic                                 outReq,
  input  logic                                 outAck
);
  import nocPkg::*;

  flitKindT [NumPorts-1:0] inKind;

  grantIf grantBus ();

  // arbiter only looks at the kind field.
  for (genvar i = 0; i < NumPorts; i++)
  begin : gKind
    assign inKind[i] = inFlit[i].kind;
  end

  switchArbiter arb0 (
    .clk    (clk),
    .rst    (rst),
    .inReq  (inReq),
    .inKind (inKind),
    .grant  (grantBus.arb)
  );

  packetTimer timer0 (
    .clk   (clk),
    .rst   (rst),
    .grant (grantBus.timer)
  );

  flitCrossbar xbar0 (
    .clk     (clk),
    .rst     (rst),
    .inFlit  (inFlit),
    .inReq   (inReq),
    .inAck   (inAck),
    .outFlit (outFlit),
    .outReq  (outReq),
    .outAck  (outAck),
    .grant   (grantBus.xbar)
  );

endmodule

// ==== rtl/flitCrossbar.sv ====
`timescale 1ns/1ps

module flitCrossbar (
  input  logic                                 clk,
  input  logic                                 rst,
  input  nocPkg::flitT [nocPkg::NumPorts-1:0]  inFlit,
  input  logic [nocPkg::NumPorts-1:0]          inReq,
  output logic [nocPkg::NumPorts-1:0]          inAck,
  output nocPkg::flitT                         outFlit,
  output logic                                 outReq,
  input  logic                                 outAck,
  grantIf.xbar                                 grant
);
  import nocPkg::*;

  typedef enum logic [1:0] {
    phIdle,
    phLaunch,
    phWaitAck,
    phClose
  } phaseT;

  phaseT phase;
  flitT  selFlit;
  logic  selReq;
  logic  capture;
  logic  closing;

  assign selFlit = inFlit[grant.grantPort];
  assign selReq  = inReq[grant.grantPort];

  // the cycle after a delivery is skipped so a finished grant is never reused.
  assign capture = (phase == phIdle) && grant.grantValid && selReq && !grant.flitSent;
  assign closing = (phase == phClose) && !selReq && !outAck;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      phase          <= phIdle;
      outReq         <= 1'b0;
      inAck          <= '0;
      grant.flitSent <= 1'b0;
    end
    else
    begin
      grant.flitSent <= 1'b0;
      case (phase)
        phIdle:
          if (capture)
            phase <= phLaunch;
        phLaunch:
        begin
          outReq <= 1'b1; // flit already stable.
          phase  <= phWaitAck;
        end
        phWaitAck:
          if (outAck)
          begin
            outReq                <= 1'b0;
            inAck[grant.grantPort] <= 1'b1;
            phase                 <= phClose;
          end
        phClose:
          if (closing)
          begin
            inAck          <= '0;
            grant.flitSent <= 1'b1;
            phase          <= phIdle;
          end
        default:
          phase <= phIdle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (capture)
      outFlit <= selFlit;
    if (closing)
      grant.sentFlit <= outFlit; // reported with flitSent.
  end

  ackOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(inAck));

  ackGranted: assert property (@(posedge clk) disable iff (rst)
    |inAck |-> grant.grantValid && inAck[grant.grantPort]);

  reqHeld: assert property (@(posedge clk) disable iff (rst)
    outReq && !outAck |=> outReq);

endmodule

// ==== rtl/packetTimer.sv ====
`timescale 1ns/1ps

module packetTimer (
  input  logic   clk,
  input  logic   rst,
  grantIf.timer  grant
);
  import nocPkg::*;

  logic [LengthWidth-1:0] remaining;
  logic [LengthWidth-1:0] headLength;
  logic                   isHead;

  assign isHead     = grant.sentFlit.kind == kindHead;
  assign headLength = grant.sentFlit.payload[LengthWidth-1:0];

  always_ff @(posedge clk)
  begin
    if (rst)
      remaining <= '0;
    else if (grant.flitSent)
    begin
      if (isHead)
        remaining <= headLength; // flits still to come.
      else
        remaining <= remaining - 1'b1;
    end
  end

  // ends on an empty head or on the last counted flit.
  always_comb
  begin
    grant.packetDone = 1'b0;
    if (grant.flitSent)
    begin
      if (isHead)
        grant.packetDone = headLength == '0;
      else
        grant.packetDone = remaining == LengthWidth'(1);
    end
  end

  // no new head before the current packet has ended.
  noInterleave: assert property (@(posedge clk) disable iff (rst)
    grant.flitSent && isHead |-> remaining == '0);

endmodule

// ==== rtl/switchArbiter.sv ====
`timescale 1ns/1ps

module switchArbiter (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic [nocPkg::NumPorts-1:0]              inReq,
  input  nocPkg::flitKindT [nocPkg::NumPorts-1:0]  inKind,
  grantIf.arb                                      grant
);
  import nocPkg::*;

  arbStateT            state;
  arbStateT            nextState;
  portT                heldPort;
  logic [NumPorts-1:0] headReq;
  int unsigned         lastIdx;

  // first head request after the last served port, wrapping around.
  function automatic arbStateT pickNext(input logic [NumPorts-1:0] cand,
                                        input int unsigned last);
    arbStateT    pick;
    logic        found;
    int unsigned idx;
    pick  = stIdle;
    found = 1'b0;
    for (int unsigned off = 1; off <= NumPorts; off++)
    begin
      idx = (last + off) % NumPorts;
      if (!found && cand[idx])
      begin
        pick  = arbStateT'(6'b000010 << idx);
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  // only a head may open a packet.
  for (genvar i = 0; i < NumPorts; i++)
  begin : gHeadReq
    assign headReq[i] = inReq[i] && (inKind[i] == kindHead);
  end

  always_comb
  begin
    case (state)
      stNorth: heldPort = portNorth;
      stEast:  heldPort = portEast;
      stWest:  heldPort = portWest;
      stSouth: heldPort = portSouth;
      default: heldPort = portLocal;
    endcase
  end

  // from idle the search begins at local.
  assign lastIdx = (state == stIdle) ? NumPorts - 1 : heldPort;

  always_comb
  begin
    nextState = state;
    case (state)
      stIdle:
        nextState = pickNext(headReq, lastIdx);
      stLocal, stNorth, stEast, stWest, stSouth:
        if (grant.packetDone)
          nextState = pickNext(headReq, lastIdx); // served port goes last.
      default:
        nextState = stIdle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= stIdle;
    else
      state <= nextState;
  end

  assign grant.grantValid = state inside {stLocal, stNorth, stEast, stWest, stSouth};
  assign grant.grantPort  = heldPort;

  // a grant lasts until the timer ends the packet.
  holdGrant: assert property (@(posedge clk) disable iff (rst)
    grant.grantValid && !grant.packetDone |=> $stable(state));

endmodule

// ==== rtl/grantIf.sv ====
`timescale 1ns/1ps

interface grantIf;
  import nocPkg::*;

  logic grantValid; // an input holds the output.
  portT grantPort;  // which input holds it.
  logic flitSent;   // input handshake closed.
  flitT sentFlit;   // flit just delivered.
  logic packetDone; // last flit of the packet delivered.

  modport arb (
    output grantValid,
    output grantPort,
    input  packetDone
  );

  modport xbar (
    input  grantValid,
    input  grantPort,
    output flitSent,
    output sentFlit
  );

  modport timer (
    input  flitSent,
    input  sentFlit,
    output packetDone
  );

endinterface

// ==== rtl/nocPkg.sv ====
package nocPkg;

  localparam int NumPorts     = 5;  // router inputs.
  localparam int PayloadWidth = 16;
  localparam int LengthWidth  = 12; // length field and timer count.

  // head uses the same id value as the older router.
  typedef enum logic [1:0] {
    kindHead = 2'b01,
    kindBody = 2'b10,
    kindTail = 2'b11
  } flitKindT;

  // head payload holds the number of flits that follow it.
  typedef struct packed {
    flitKindT                kind;
    logic [PayloadWidth-1:0] payload;
  } flitT;

  // round-robin order follows these indices.
  typedef enum logic [2:0] {
    portLocal = 3'd0,
    portNorth = 3'd1,
    portEast  = 3'd2,
    portWest  = 3'd3,
    portSouth = 3'd4
  } portT;

  // one-hot, bit 0 is idle, bit i+1 is port i.
  typedef enum logic [5:0] {
    stIdle  = 6'b000001,
    stLocal = 6'b000010,
    stNorth = 6'b000100,
    stEast  = 6'b001000,
    stWest  = 6'b010000,
    stSouth = 6'b100000
  } arbStateT;

endpackage
